// ==== cpu.f ====
design/cpu_pkg.sv
design/cpu_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_bank.sv
design/alu_stage.sv
design/mem_stage.sv
design/cpu.sv
testbench/cpu_sva.sv
testbench/cpu_tb.sv

// ==== design/alu_stage.sv ====
`default_nettype none

module alu_stage (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  exec_if.dst                             ex_i,
  output logic                            redirect_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]  target_o,
  mem_if.src                              mem_o
);

  logic [cpu_pkg::DATA_WIDTH-1:0] alu_out;
  logic [cpu_pkg::DATA_WIDTH-1:0] result;
  logic [cpu_pkg::ADDR_WIDTH-1:0] pc_next;
  logic                           taken;

  assign pc_next = ex_i.pc + 1'b1;

  always_comb begin
    case (ex_i.funct)
      cpu_pkg::FN_ADD: alu_out = ex_i.a_data + ex_i.b_data;
      cpu_pkg::FN_SUB: alu_out = ex_i.a_data - ex_i.b_data;
      cpu_pkg::FN_AND: alu_out = ex_i.a_data & ex_i.b_data;
      cpu_pkg::FN_OR:  alu_out = ex_i.a_data | ex_i.b_data;
      cpu_pkg::FN_XOR: alu_out = ex_i.a_data ^ ex_i.b_data;
      cpu_pkg::FN_SLT: alu_out = {31'd0, $signed(ex_i.a_data) < $signed(ex_i.b_data)};
      cpu_pkg::FN_SLL: alu_out = ex_i.a_data << ex_i.b_data[4:0];
      cpu_pkg::FN_SRL: alu_out = ex_i.a_data >> ex_i.b_data[4:0];
      default:         alu_out = '0;
    endcase
  end

  always_comb begin
    taken  = 1'b0;
    result = ex_i.a_data + ex_i.imm; // ADDI, LW, SW address
    case (ex_i.opcode)
      cpu_pkg::OP_ALU: result = alu_out;
      cpu_pkg::OP_BEQ: taken = (ex_i.a_data == ex_i.b_data);
      cpu_pkg::OP_BNE: taken = (ex_i.a_data != ex_i.b_data);
      cpu_pkg::OP_JAL: begin
        taken  = 1'b1;
        result = {{(cpu_pkg::DATA_WIDTH-cpu_pkg::ADDR_WIDTH){1'b0}}, pc_next}; // Link
      end
      default: ;
    endcase
  end

  assign redirect_o = ex_i.valid & taken;
  assign target_o   = pc_next + ex_i.imm[cpu_pkg::ADDR_WIDTH-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_o.valid <= 1'b0;
    end else begin
      mem_o.valid <= ex_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_o.pc         <= ex_i.pc;
    mem_o.rd         <= ex_i.rd;
    mem_o.wr_en      <= ex_i.wr_en;
    mem_o.is_load    <= (ex_i.opcode == cpu_pkg::OP_LW);
    mem_o.is_store   <= (ex_i.opcode == cpu_pkg::OP_SW);
    mem_o.result     <= result;
    mem_o.store_data <= ex_i.b_data;
  end

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`default_nettype none

module cpu (
  input  wire logic                              clk_i,
  input  wire logic                              rst_i,
  input  wire logic                              imem_we_i,
  input  wire logic [cpu_pkg::ADDR_WIDTH-1:0]    imem_addr_i,
  input  wire logic [cpu_pkg::INSTR_WIDTH-1:0]   imem_data_i,
  output logic                                   retire_valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]         retire_pc_o,
  output logic                                   retire_wr_o,
  output logic [cpu_pkg::REG_WIDTH-1:0]          retire_rd_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]         retire_data_o,
  output logic                                   store_valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]         store_addr_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]         store_data_o
);

  logic                           fd_valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0] fd_pc;
  cpu_pkg::instr_u                fd_instr;
  logic                           redirect;
  logic [cpu_pkg::ADDR_WIDTH-1:0] target;
  logic [cpu_pkg::REG_WIDTH-1:0]  ra_addr;
  logic [cpu_pkg::REG_WIDTH-1:0]  rb_addr;
  logic [cpu_pkg::DATA_WIDTH-1:0] ra_data;
  logic [cpu_pkg::DATA_WIDTH-1:0] rb_data;

  exec_if ex_bus ();
  mem_if  mem_bus ();
  wb_if   wb_bus ();

  fetch_stage fetch_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .imem_we_i   (imem_we_i),
    .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i),
    .redirect_i  (redirect),
    .target_i    (target),
    .valid_o     (fd_valid),
    .pc_o        (fd_pc),
    .instr_o     (fd_instr)
  );

  decode_stage decode_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (fd_valid),
    .pc_i      (fd_pc),
    .instr_i   (fd_instr),
    .flush_i   (redirect),
    .ra_data_i (ra_data),
    .rb_data_i (rb_data),
    .ra_addr_o (ra_addr),
    .rb_addr_o (rb_addr),
    .ex_o      (ex_bus)
  );

  reg_bank regs_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ra_addr_i (ra_addr),
    .rb_addr_i (rb_addr),
    .wb_i      (wb_bus),
    .ra_data_o (ra_data),
    .rb_data_o (rb_data)
  );

  alu_stage alu_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ex_i       (ex_bus),
    .redirect_o (redirect),
    .target_o   (target),
    .mem_o      (mem_bus)
  );

  mem_stage mem_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mem_i         (mem_bus),
    .store_valid_o (store_valid_o),
    .store_addr_o  (store_addr_o),
    .store_data_o  (store_data_o),
    .wb_o          (wb_bus)
  );

  // Retire port mirrors writeback
  assign retire_valid_o = wb_bus.valid;
  assign retire_pc_o    = wb_bus.pc;
  assign retire_wr_o    = wb_bus.wr_en;
  assign retire_rd_o    = wb_bus.rd;
  assign retire_data_o  = wb_bus.data;

endmodule

`default_nettype wire

// ==== design/cpu_if.sv ====
`default_nettype none

// Decode to ALU
interface exec_if;
  logic                             valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0]   pc;
  logic [cpu_pkg::OPCODE_WIDTH-1:0] opcode;
  logic [cpu_pkg::FUNCT_WIDTH-1:0]  funct;
  logic [cpu_pkg::REG_WIDTH-1:0]    rd;
  logic                             wr_en;
  logic [cpu_pkg::DATA_WIDTH-1:0]   a_data;
  logic [cpu_pkg::DATA_WIDTH-1:0]   b_data;
  logic [cpu_pkg::DATA_WIDTH-1:0]   imm;

  modport src (output valid, pc, opcode, funct, rd, wr_en, a_data, b_data, imm);
  modport dst (input valid, pc, opcode, funct, rd, wr_en, a_data, b_data, imm);
endinterface

// ALU to memory
interface mem_if;
  logic                           valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0] pc;
  logic [cpu_pkg::REG_WIDTH-1:0]  rd;
  logic                           wr_en;
  logic                           is_load;
  logic                           is_store;
  logic [cpu_pkg::DATA_WIDTH-1:0] result;
  logic [cpu_pkg::DATA_WIDTH-1:0] store_data;

  modport src (output valid, pc, rd, wr_en, is_load, is_store, result, store_data);
  modport dst (input valid, pc, rd, wr_en, is_load, is_store, result, store_data);
endinterface

// Writeback to register file and retire port
interface wb_if;
  logic                           valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0] pc;
  logic [cpu_pkg::REG_WIDTH-1:0]  rd;
  logic                           wr_en;
  logic [cpu_pkg::DATA_WIDTH-1:0] data;

  modport src (output valid, pc, rd, wr_en, data);
  modport dst (input valid, pc, rd, wr_en, data);
endinterface

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 8;
  localparam int REG_WIDTH    = 3;
  localparam int INSTR_WIDTH  = 16;
  localparam int OPCODE_WIDTH = 4;
  localparam int FUNCT_WIDTH  = 3;
  localparam int IMM_WIDTH    = 6;
  localparam int IMEM_DEPTH   = 256;
  localparam int DMEM_DEPTH   = 256;

  localparam logic [OPCODE_WIDTH-1:0] OP_NOP  = 4'h0;
  localparam logic [OPCODE_WIDTH-1:0] OP_ALU  = 4'h1;
  localparam logic [OPCODE_WIDTH-1:0] OP_ADDI = 4'h2;
  localparam logic [OPCODE_WIDTH-1:0] OP_LW   = 4'h3;
  localparam logic [OPCODE_WIDTH-1:0] OP_SW   = 4'h4;
  localparam logic [OPCODE_WIDTH-1:0] OP_BEQ  = 4'h5;
  localparam logic [OPCODE_WIDTH-1:0] OP_BNE  = 4'h6;
  localparam logic [OPCODE_WIDTH-1:0] OP_JAL  = 4'h7;

  localparam logic [FUNCT_WIDTH-1:0] FN_ADD = 3'd0;
  localparam logic [FUNCT_WIDTH-1:0] FN_SUB = 3'd1;
  localparam logic [FUNCT_WIDTH-1:0] FN_AND = 3'd2;
  localparam logic [FUNCT_WIDTH-1:0] FN_OR  = 3'd3;
  localparam logic [FUNCT_WIDTH-1:0] FN_XOR = 3'd4;
  localparam logic [FUNCT_WIDTH-1:0] FN_SLT = 3'd5;
  localparam logic [FUNCT_WIDTH-1:0] FN_SLL = 3'd6;
  localparam logic [FUNCT_WIDTH-1:0] FN_SRL = 3'd7;

  typedef struct packed {
    logic [OPCODE_WIDTH-1:0] opcode;
    logic [REG_WIDTH-1:0]    rd;
    logic [REG_WIDTH-1:0]    ra;
    logic [REG_WIDTH-1:0]    rb;
    logic [FUNCT_WIDTH-1:0]  funct;
  } instr_r_t;

  typedef struct packed {
    logic [OPCODE_WIDTH-1:0]     opcode;
    logic [REG_WIDTH-1:0]        rd;
    logic [REG_WIDTH-1:0]        ra;
    logic signed [IMM_WIDTH-1:0] imm6;
  } instr_i_t;

  // Same 16 bits, two decodings
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  wire logic                            clk_i,
  input  wire logic                            rst_i,
  input  wire logic                            valid_i,
  input  wire logic [cpu_pkg::ADDR_WIDTH-1:0]  pc_i,
  input  cpu_pkg::instr_u                      instr_i,
  input  wire logic                            flush_i,
  input  wire logic [cpu_pkg::DATA_WIDTH-1:0]  ra_data_i,
  input  wire logic [cpu_pkg::DATA_WIDTH-1:0]  rb_data_i,
  output logic [cpu_pkg::REG_WIDTH-1:0]        ra_addr_o,
  output logic [cpu_pkg::REG_WIDTH-1:0]        rb_addr_o,
  exec_if.src                                  ex_o
);

  logic [cpu_pkg::OPCODE_WIDTH-1:0] opcode;
  logic [cpu_pkg::FUNCT_WIDTH-1:0]  funct;
  logic [cpu_pkg::DATA_WIDTH-1:0]   imm;
  logic                             wr_en;

  always_comb begin
    opcode    = instr_i.r.opcode;
    ra_addr_o = instr_i.r.ra;
    rb_addr_o = instr_i.r.rb;
    funct     = cpu_pkg::FN_ADD;
    imm       = '0;
    wr_en     = 1'b0;
    if (opcode == cpu_pkg::OP_ALU) begin
      funct = instr_i.r.funct;
    end else begin
      imm = {{(cpu_pkg::DATA_WIDTH-cpu_pkg::IMM_WIDTH){instr_i.i.imm6[cpu_pkg::IMM_WIDTH-1]}},
             instr_i.i.imm6};
    end
    case (opcode)
      cpu_pkg::OP_ALU, cpu_pkg::OP_ADDI, cpu_pkg::OP_LW, cpu_pkg::OP_JAL: wr_en = 1'b1;
      cpu_pkg::OP_SW, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
        rb_addr_o = instr_i.i.rd; // rd is an operand here
      end
      cpu_pkg::OP_NOP: wr_en = 1'b0;
      default: wr_en = 1'b0;
    endcase
    if (instr_i.r.rd == '0) begin
      wr_en = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ex_o.valid <= 1'b0;
    end else begin
      ex_o.valid <= valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_o.pc     <= pc_i;
    ex_o.opcode <= opcode;
    ex_o.funct  <= funct;
    ex_o.rd     <= instr_i.r.rd;
    ex_o.wr_en  <= wr_en;
    ex_o.a_data <= ra_data_i;
    ex_o.b_data <= rb_data_i;
    ex_o.imm    <= imm;
  end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  wire logic                              clk_i,
  input  wire logic                              rst_i,
  input  wire logic                              imem_we_i,
  input  wire logic [cpu_pkg::ADDR_WIDTH-1:0]    imem_addr_i,
  input  wire logic [cpu_pkg::INSTR_WIDTH-1:0]   imem_data_i,
  input  wire logic                              redirect_i,
  input  wire logic [cpu_pkg::ADDR_WIDTH-1:0]    target_i,
  output logic                                   valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]         pc_o,
  output cpu_pkg::instr_u                        instr_o
);

  logic [cpu_pkg::INSTR_WIDTH-1:0] imem [cpu_pkg::IMEM_DEPTH];
  logic [cpu_pkg::ADDR_WIDTH-1:0]  pc_q;

  // Program load port
  always_ff @(posedge clk_i) begin
    if (imem_we_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q    <= '0;
      valid_o <= 1'b0;
    end else begin
      pc_q    <= redirect_i ? target_i : pc_q + 1'b1;
      valid_o <= ~redirect_i; // Drop the wrong-path fetch
    end
  end

  // Fetch/decode payload
  always_ff @(posedge clk_i) begin
    pc_o    <= pc_q;
    instr_o <= imem[pc_q];
  end

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
`default_nettype none

module mem_stage (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  mem_if.dst                              mem_i,
  output logic                            store_valid_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]  store_addr_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]  store_data_o,
  wb_if.src                               wb_o
);

  logic [cpu_pkg::DATA_WIDTH-1:0] dmem [cpu_pkg::DMEM_DEPTH];

  // Word address wraps at 8 bits
  assign store_valid_o = mem_i.valid & mem_i.is_store;
  assign store_addr_o  = mem_i.result[cpu_pkg::ADDR_WIDTH-1:0];
  assign store_data_o  = mem_i.store_data;

  always_ff @(posedge clk_i) begin
    if (store_valid_o) begin
      dmem[store_addr_o] <= store_data_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_o.valid <= 1'b0;
    end else begin
      wb_o.valid <= mem_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_o.pc    <= mem_i.pc;
    wb_o.rd    <= mem_i.rd;
    wb_o.wr_en <= mem_i.wr_en;
    wb_o.data  <= mem_i.is_load ? dmem[store_addr_o] : mem_i.result;
  end

endmodule

`default_nettype wire

// ==== design/reg_bank.sv ====
`default_nettype none

module reg_bank (
  input  wire logic                            clk_i,
  input  wire logic                            rst_i,
  input  wire logic [cpu_pkg::REG_WIDTH-1:0]   ra_addr_i,
  input  wire logic [cpu_pkg::REG_WIDTH-1:0]   rb_addr_i,
  wb_if.dst                                    wb_i,
  output logic [cpu_pkg::DATA_WIDTH-1:0]       ra_data_o,
  output logic [cpu_pkg::DATA_WIDTH-1:0]       rb_data_o
);

  logic [cpu_pkg::DATA_WIDTH-1:0] regs [2**cpu_pkg::REG_WIDTH];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < 2**cpu_pkg::REG_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.wr_en) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // No bypass, r0 hardwired
  assign ra_data_o = (ra_addr_i == '0) ? '0 : regs[ra_addr_i];
  assign rb_data_o = (rb_addr_i == '0) ? '0 : regs[rb_addr_i];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the cpu testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f cpu.f; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcpu_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' <<< "$output"; then
  exit 0
fi
exit 1

// ==== testbench/cpu_stim.txt ====
# t name | p start_addr(hex) count(dec) words(hex) | w rd data(hex) | s addr(hex) data(hex)
# register writes and stores in program order, every program ends in a self jump
t alu_ops
p 00 16 2205 243d 260c 0000 0000 0000 1850 1a59
        1cd2 1e5b 185c 1a8d 1cce 1e8f 1855 703f
w 1 00000005
w 2 fffffffd
w 3 0000000c
w 4 00000002
w 5 fffffff9
w 6 0000000c
w 7 0000000d
w 4 00000009
w 5 00000001
w 6 00000180
w 7 07ffffff
w 4 00000000
t reg_zero
p 00 8 2007 2209 0000 0000 0000 1408 2600 703f
w 1 00000009
w 2 00000009
w 3 00000000
t store_load
p 00 8 220a 242c 0000 0000 0000 4443 3643 703f
w 1 0000000a
w 2 ffffffec
w 3 ffffffec
s 0d ffffffec
t branches
p 00 13 2204 2404 2601 0000 0000 6285 2802 5282 2a07 2c07 2e03 2a05 703f
w 1 00000004
w 2 00000004
w 3 00000001
w 4 00000002
w 7 00000003
w 5 00000005
t jal_link
p 00 9 2401 0000 7203 2409 2609 2809 2a06 2c42 703f
w 2 00000001
w 1 00000003
w 5 00000006
w 6 00000005

// ==== testbench/cpu_sva.sv ====
`default_nettype none

module cpu_sva (
  input wire logic                             clk_i,
  input wire logic                             rst_i,
  input wire logic                             retire_valid_i,
  input wire logic [cpu_pkg::ADDR_WIDTH-1:0]   retire_pc_i,
  input wire logic                             retire_wr_i,
  input wire logic [cpu_pkg::REG_WIDTH-1:0]    retire_rd_i,
  input wire logic                             store_valid_i
);

  // Valid bits clear on the first reset edge
  reset_clears_valid: assert property (@(posedge clk_i)
    !rst_i |=> !retire_valid_i && !store_valid_i)
    else $error("retire or store valid set in the cycle after a reset cycle");

  no_write_to_r0: assert property (@(posedge clk_i) disable iff (!rst_i)
    retire_valid_i |-> !(retire_wr_i && retire_rd_i == '0))
    else $error("retire port reports a write to register 0");

  // A redirect leaves a two cycle bubble, so back to back retirements are sequential
  pc_in_sequence: assert property (@(posedge clk_i) disable iff (!rst_i)
    retire_valid_i && $past(retire_valid_i) |-> retire_pc_i == $past(retire_pc_i) + 1'b1)
    else $error("consecutive retirements with pc values not one apart");

endmodule

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`default_nettype none

module cpu_tb;

  localparam int RESET_CYCLES = 5;
  localparam int DRAIN_CYCLES = 6; // Window for late extra events

  logic                            clk = 1'b0;
  logic                            rst;
  logic                            imem_we;
  logic [cpu_pkg::ADDR_WIDTH-1:0]  imem_addr;
  logic [cpu_pkg::INSTR_WIDTH-1:0] imem_data;
  logic                            retire_valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0]  retire_pc;
  logic                            retire_wr;
  logic [cpu_pkg::REG_WIDTH-1:0]   retire_rd;
  logic [cpu_pkg::DATA_WIDTH-1:0]  retire_data;
  logic                            store_valid;
  logic [cpu_pkg::ADDR_WIDTH-1:0]  store_addr;
  logic [cpu_pkg::DATA_WIDTH-1:0]  store_data;

  // Whole stimulus file, flat over all tests
  string                           test_names [$];
  int                              load_cnt [$];
  int                              write_cnt [$];
  int                              store_cnt [$];
  logic [cpu_pkg::ADDR_WIDTH-1:0]  load_addr [$];
  cpu_pkg::instr_u                 load_word [$];
  logic [cpu_pkg::REG_WIDTH-1:0]   write_rd [$];
  logic [cpu_pkg::DATA_WIDTH-1:0]  write_data [$];
  logic [cpu_pkg::ADDR_WIDTH-1:0]  st_addr [$];
  logic [cpu_pkg::DATA_WIDTH-1:0]  st_data [$];

  // Still outstanding in the running test
  logic [cpu_pkg::REG_WIDTH-1:0]   exp_rd [$];
  logic [cpu_pkg::DATA_WIDTH-1:0]  exp_data [$];
  logic [cpu_pkg::ADDR_WIDTH-1:0]  exp_saddr [$];
  logic [cpu_pkg::DATA_WIDTH-1:0]  exp_sdata [$];

  string cur_name;
  bit    checking = 1'b0;
  int    cycle_count = 0;
  int    cycle_limit = 0;
  int    error_count = 0;
  int    test_errors = 0;
  int    failed_tests = 0;
  int    load_base = 0;
  int    write_base = 0;
  int    store_base = 0;
  int    fd;

  always #4 clk = ~clk;

  cpu dut_i (
    .clk_i          (clk),
    .rst_i          (rst),
    .imem_we_i      (imem_we),
    .imem_addr_i    (imem_addr),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_wr_o    (retire_wr),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data),
    .store_valid_o  (store_valid),
    .store_addr_o   (store_addr),
    .store_data_o   (store_data)
  );

  bind cpu cpu_sva sva_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .retire_valid_i (retire_valid_o),
    .retire_pc_i    (retire_pc_o),
    .retire_wr_i    (retire_wr_o),
    .retire_rd_i    (retire_rd_o),
    .store_valid_i  (store_valid_o)
  );

  task automatic count_error();
    test_errors++;
    error_count++;
  endtask

  task automatic read_stimulus(input int f);
    logic [7:0]       tag;
    logic [8*32-1:0]  name_vec;
    logic [8*128-1:0] rest;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      addr;
    int               n;
    int               k;
    int               rc;
    rc = $fscanf(f, " %c", tag);
    while (rc == 1) begin
      if (tag == "#") begin
        rc = $fgets(rest, f);
      end else if (tag == "t") begin
        rc = $fscanf(f, "%s", name_vec);
        test_names.push_back(string'(name_vec));
        load_cnt.push_back(0);
        write_cnt.push_back(0);
        store_cnt.push_back(0);
        cycle_limit += 40;
      end else if (tag == "p") begin
        rc = $fscanf(f, "%h %d", a, n);
        for (k = 0; k < n; k++) begin
          rc = $fscanf(f, "%h", b);
          addr = a + k; // Wraps at 8 bits
          load_addr.push_back(addr[cpu_pkg::ADDR_WIDTH-1:0]);
          load_word.push_back(cpu_pkg::instr_u'(b[cpu_pkg::INSTR_WIDTH-1:0]));
        end
        load_cnt[load_cnt.size()-1] += n;
        cycle_limit += 4 * n;
      end else if (tag == "w") begin
        rc = $fscanf(f, "%h %h", a, b);
        write_rd.push_back(a[cpu_pkg::REG_WIDTH-1:0]);
        write_data.push_back(b);
        write_cnt[write_cnt.size()-1] += 1;
      end else if (tag == "s") begin
        rc = $fscanf(f, "%h %h", a, b);
        st_addr.push_back(a[cpu_pkg::ADDR_WIDTH-1:0]);
        st_data.push_back(b);
        store_cnt[store_cnt.size()-1] += 1;
      end else begin
        $display("stimulus file holds an unknown entry '%c'", tag);
        error_count++;
        rc = $fgets(rest, f);
      end
      rc = $fscanf(f, " %c", tag);
    end
  endtask

  task automatic run_test(input int t);
    int hold;
    int c;
    cur_name = test_names[t];
    test_errors = 0;
    exp_rd.delete();
    exp_data.delete();
    exp_saddr.delete();
    exp_sdata.delete();
    for (c = 0; c < write_cnt[t]; c++) begin
      exp_rd.push_back(write_rd[write_base + c]);
      exp_data.push_back(write_data[write_base + c]);
    end
    for (c = 0; c < store_cnt[t]; c++) begin
      exp_saddr.push_back(st_addr[store_base + c]);
      exp_sdata.push_back(st_data[store_base + c]);
    end
    // Program goes in while reset is held
    hold = (load_cnt[t] + 1 > RESET_CYCLES) ? load_cnt[t] + 1 : RESET_CYCLES;
    for (c = 0; c < hold; c++) begin
      @(posedge clk);
      rst     <= 1'b0;
      imem_we <= (c < load_cnt[t]);
      if (c < load_cnt[t]) begin
        imem_addr <= load_addr[load_base + c];
        imem_data <= load_word[load_base + c];
      end
    end
    @(posedge clk);
    imem_we  <= 1'b0;
    rst      <= 1'b1;
    checking = 1'b1;
    while (exp_rd.size() > 0 || exp_saddr.size() > 0) begin
      @(posedge clk);
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    checking = 1'b0;
    load_base  += load_cnt[t];
    write_base += write_cnt[t];
    store_base += store_cnt[t];
    if (test_errors == 0) begin
      $display("test %s: ok", cur_name);
    end else begin
      $display("test %s: %0d error(s)", cur_name, test_errors);
      failed_tests++;
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (checking && retire_valid && retire_wr) begin
      if (exp_rd.size() == 0) begin
        $display("%s: unexpected register write r%0d=%h from pc %h",
                 cur_name, retire_rd, retire_data, retire_pc);
        count_error();
      end else begin
        if (retire_rd !== exp_rd[0] || retire_data !== exp_data[0]) begin
          $display("FAILED %s: expected r%0d=%h, actual r%0d=%h",
                   cur_name, exp_rd[0], exp_data[0], retire_rd, retire_data);
          count_error();
        end
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
      end
    end
    if (checking && store_valid) begin
      if (exp_saddr.size() == 0) begin
        $display("%s: unexpected store of %h to address %h", cur_name, store_data, store_addr);
        count_error();
      end else begin
        if (store_addr !== exp_saddr[0] || store_data !== exp_sdata[0]) begin
          $display("FAILED %s: expected store [%h]=%h, actual [%h]=%h",
                   cur_name, exp_saddr[0], exp_sdata[0], store_addr, store_data);
          count_error();
        end
        void'(exp_saddr.pop_front());
        void'(exp_sdata.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    rst       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    fd = $fopen("testbench/cpu_stim.txt", "r");
    if (fd == 0) begin
      $display("stimulus file testbench/cpu_stim.txt could not be opened");
      $display("** FAIL **");
      $finish;
    end else begin
      read_stimulus(fd);
      $fclose(fd);
      for (int t = 0; t < test_names.size(); t++) begin
        run_test(t);
      end
      $display("%0d tests, %0d failed, %0d errors", test_names.size(), failed_tests,
               error_count);
      if (error_count == 0 && test_names.size() > 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
